// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= mips_tb
FILELIST ?= mips_sys.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

.PHONY: sim clean

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu (
	input logic [mips_pkg::word_w-1:0] a,
	input logic [mips_pkg::word_w-1:0] b,
	input mips_pkg::aluop_e alu_op,
	input logic [5:0] funct,
	output logic [mips_pkg::word_w-1:0] result,
	output logic zero
);

	always_comb begin
		case (alu_op)
			// Address generation for lw and sw
			mips_pkg::aluop_add: result = a + b;
			// beq compare
			mips_pkg::aluop_sub: result = a - b;
			mips_pkg::aluop_funct: begin
				case (funct)
					mips_pkg::fn_add: result = a + b;
					mips_pkg::fn_sub: result = a - b;
					mips_pkg::fn_and: result = a & b;
					mips_pkg::fn_or: result = a | b;
					// Signed set on less than
					mips_pkg::fn_slt: result = {{(mips_pkg::word_w-1){1'b0}},
						($signed(a) < $signed(b))};
					default: result = '0;
				endcase
			end
			default: result = '0;
		endcase
	end

	// Branch condition
	assign zero = (result == '0);

endmodule

// ==== design/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
	input mips_pkg::opcode_e opcode,
	// Write back
	output logic reg_write,
	output logic mem_to_reg,
	// Memory
	output logic branch,
	output logic mem_read,
	output logic mem_write,
	// Execute
	output logic reg_dst,
	output mips_pkg::aluop_e alu_op,
	output logic alu_src,
	// Stop the sequencer
	output logic halt
);

	always_comb begin
		// Everything off unless the opcode turns it on
		reg_write = 1'b0;
		mem_to_reg = 1'b0;
		branch = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		reg_dst = 1'b0;
		alu_op = mips_pkg::aluop_add;
		alu_src = 1'b0;
		halt = 1'b0;

		case (opcode)
			mips_pkg::op_rtype: begin
				// rd <= rs op rt
				reg_write = 1'b1;
				reg_dst = 1'b1;
				alu_op = mips_pkg::aluop_funct;
			end
			mips_pkg::op_lw: begin
				// rt <= mem[rs + imm]
				reg_write = 1'b1;
				mem_to_reg = 1'b1;
				mem_read = 1'b1;
				alu_src = 1'b1;
			end
			mips_pkg::op_sw: begin
				// mem[rs + imm] <= rt
				mem_write = 1'b1;
				alu_src = 1'b1;
			end
			mips_pkg::op_beq: begin
				// Compare by subtraction
				branch = 1'b1;
				alu_op = mips_pkg::aluop_sub;
			end
			mips_pkg::op_halt: begin
				halt = 1'b1;
			end
			default: begin
				// Unknown opcode stops the core
				halt = 1'b1;
			end
		endcase
	end

endmodule

// ==== design/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
	input logic clk,
	input logic rst,
	input logic run,
	// From fetch
	input logic [mips_pkg::word_w-1:0] instr,
	input logic [mips_pkg::addr_w-1:0] instr_pc,
	input logic instr_valid,
	output logic instr_take,
	output logic branch_taken,
	output logic [mips_pkg::addr_w-1:0] branch_target,
	output logic halted,
	// Data port to the arbiter
	output logic data_req,
	output logic data_we,
	output logic [mips_pkg::addr_w-1:0] data_addr,
	output logic [mips_pkg::word_w-1:0] data_wdata,
	input logic data_grant,
	input logic data_rvalid,
	input logic [mips_pkg::word_w-1:0] data_rdata
);

	mips_pkg::exec_state_e state;

	// Instruction under execution
	logic [mips_pkg::word_w-1:0] ir;
	logic [mips_pkg::addr_w-1:0] ir_pc;

	// Decoder outputs
	logic reg_write;
	logic mem_to_reg;
	logic branch;
	logic mem_read;
	logic mem_write;
	logic reg_dst;
	logic alu_src;
	logic halt;
	mips_pkg::aluop_e alu_op;

	logic [mips_pkg::word_w-1:0] rs_data;
	logic [mips_pkg::word_w-1:0] rt_data;
	logic [mips_pkg::word_w-1:0] imm_ext;
	logic [mips_pkg::word_w-1:0] alu_b;
	logic [mips_pkg::word_w-1:0] alu_result;
	logic alu_zero;
	logic wr_en;
	logic [mips_pkg::reg_addr_w-1:0] wr_addr;
	logic [mips_pkg::word_w-1:0] wr_data;

	////////////////////
	// Datapath
	////////////////////

	control_unit control_unit_i (
		.opcode(mips_pkg::opcode_e'(ir[31:26])),
		.reg_write(reg_write),
		.mem_to_reg(mem_to_reg),
		.branch(branch),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.reg_dst(reg_dst),
		.alu_op(alu_op),
		.alu_src(alu_src),
		.halt(halt)
	);

	reg_file reg_file_i (
		.clk(clk),
		.rst(rst),
		.rs_addr(ir[25:21]),
		.rt_addr(ir[20:16]),
		.wr_addr(wr_addr),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.rs_data(rs_data),
		.rt_data(rt_data)
	);

	// Sign-extended 16-bit immediate
	assign imm_ext = {{16{ir[15]}}, ir[15:0]};
	assign alu_b = alu_src ? imm_ext : rt_data;

	alu alu_i (
		.a(rs_data),
		.b(alu_b),
		.alu_op(alu_op),
		.funct(ir[5:0]),
		.result(alu_result),
		.zero(alu_zero)
	);

	// rd for R-type, rt for lw
	assign wr_addr = reg_dst ? ir[15:11] : ir[20:16];
	assign wr_data = mem_to_reg ? data_rdata : alu_result;
	// R-type in execute, lw when its data returns
	assign wr_en = reg_write && (((state == mips_pkg::st_exec) && !mem_to_reg) ||
		((state == mips_pkg::st_wb) && data_rvalid));

	// Word offset relative to the next PC
	assign branch_target = ir_pc + 1'b1 + imm_ext[mips_pkg::addr_w-1:0];
	assign branch_taken = (state == mips_pkg::st_exec) && branch && alu_zero;

	// Byte address down to a word address
	assign data_req = (state == mips_pkg::st_mem);
	assign data_we = mem_write;
	assign data_addr = alu_result[mips_pkg::addr_w+1:2];
	assign data_wdata = rt_data;

	////////////////////
	// Sequencer
	////////////////////

	assign instr_take = (state == mips_pkg::st_idle) && !halted && instr_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mips_pkg::st_idle;
			halted <= 1'b1;
		end else begin
			case (state)
				mips_pkg::st_idle: begin
					// Host hands control back
					if (run) begin
						halted <= 1'b0;
					end
					if (instr_take) begin
						state <= mips_pkg::st_exec;
					end
				end
				mips_pkg::st_exec: begin
					if (halt) begin
						halted <= 1'b1;
						state <= mips_pkg::st_idle;
					end else if (mem_read || mem_write) begin
						state <= mips_pkg::st_mem;
					end else begin
						// R-type and beq done here
						state <= mips_pkg::st_idle;
					end
				end
				mips_pkg::st_mem: begin
					// Hold the request until granted
					if (data_grant) begin
						state <= mem_write ? mips_pkg::st_idle : mips_pkg::st_wb;
					end
				end
				mips_pkg::st_wb: begin
					if (data_rvalid) begin
						state <= mips_pkg::st_idle;
					end
				end
				default: state <= mips_pkg::st_idle;
			endcase
		end
	end

	// Latch the taken instruction
	always_ff @(posedge clk) begin
		if (instr_take) begin
			ir <= instr;
			ir_pc <= instr_pc;
		end
	end

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
	input logic clk,
	input logic rst,
	input logic halted,
	input logic branch_taken,
	input logic [mips_pkg::addr_w-1:0] branch_target,
	input logic instr_take,
	// Arbiter side
	input logic grant,
	input logic rvalid,
	input logic [mips_pkg::word_w-1:0] rdata,
	output logic req,
	output logic [mips_pkg::addr_w-1:0] addr,
	// Execute side
	output logic [mips_pkg::word_w-1:0] instr,
	output logic [mips_pkg::addr_w-1:0] instr_pc,
	output logic instr_valid
);

	logic [mips_pkg::addr_w-1:0] pc;
	// Address of the read in flight
	logic [mips_pkg::addr_w-1:0] pend_pc;
	logic pending;
	// Read in flight belongs to a dropped path
	logic stale;
	logic buf_valid;
	logic flush;

	// Taken branch or stopped core empties the pipe
	assign flush = branch_taken | halted;

	// Next fetch once the buffer frees up
	assign req = !halted && !pending && (!buf_valid || instr_take);
	assign addr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			pending <= 1'b0;
			stale <= 1'b0;
			buf_valid <= 1'b0;
		end else begin
			// Execute consumed the buffer
			if (instr_take) begin
				buf_valid <= 1'b0;
			end
			// Read return
			if (rvalid) begin
				pending <= 1'b0;
				stale <= 1'b0;
				if (!stale && !flush) begin
					buf_valid <= 1'b1;
				end
			end
			// Read issued
			if (grant) begin
				pending <= 1'b1;
				pc <= pc + 1'b1;
				stale <= flush;
			end
			// Redirect overrides the increment
			if (flush) begin
				buf_valid <= 1'b0;
				if (pending && !rvalid) begin
					stale <= 1'b1;
				end
				// Restart from 0 after run
				pc <= halted ? '0 : branch_target;
			end
		end
	end

	// Buffer payload
	always_ff @(posedge clk) begin
		if (grant) begin
			pend_pc <= pc;
		end
		if (rvalid && !stale) begin
			instr <= rdata;
			instr_pc <= pend_pc;
		end
	end

	assign instr_valid = buf_valid;

endmodule

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
	input logic clk,
	input logic rst,
	input logic [mips_pkg::req_n-1:0] req,
	// Host loader
	input logic host_we,
	input logic [mips_pkg::addr_w-1:0] host_addr,
	input logic [mips_pkg::word_w-1:0] host_wdata,
	// Execute unit data access
	input logic data_we,
	input logic [mips_pkg::addr_w-1:0] data_addr,
	input logic [mips_pkg::word_w-1:0] data_wdata,
	// Instruction prefetch
	input logic fetch_we,
	input logic [mips_pkg::addr_w-1:0] fetch_addr,
	input logic [mips_pkg::word_w-1:0] fetch_wdata,
	output logic [mips_pkg::req_n-1:0] grant,
	output logic [mips_pkg::req_n-1:0] rvalid,
	// Memory side
	output logic mem_en,
	output logic mem_we,
	output logic [mips_pkg::addr_w-1:0] mem_addr,
	output logic [mips_pkg::word_w-1:0] mem_wdata,
	input logic [mips_pkg::word_w-1:0] mem_rdata,
	output logic [mips_pkg::word_w-1:0] rdata
);

	// One-hot owner of the read in flight
	logic [mips_pkg::req_n-1:0] rd_owner;

	////////////////////
	// Fixed priority
	////////////////////

	always_comb begin
		grant = '0;
		mem_we = 1'b0;
		mem_addr = fetch_addr;
		mem_wdata = fetch_wdata;
		if (req[mips_pkg::req_host]) begin
			grant[mips_pkg::req_host] = 1'b1;
			mem_we = host_we;
			mem_addr = host_addr;
			mem_wdata = host_wdata;
		end else if (req[mips_pkg::req_data]) begin
			grant[mips_pkg::req_data] = 1'b1;
			mem_we = data_we;
			mem_addr = data_addr;
			mem_wdata = data_wdata;
		end else if (req[mips_pkg::req_fetch]) begin
			// Lowest priority, waits out the other two
			grant[mips_pkg::req_fetch] = 1'b1;
			mem_we = fetch_we;
		end
	end

	// Any request gets the port this cycle
	assign mem_en = |req;

	////////////////////
	// Read return
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_owner <= '0;
		end else begin
			// Only reads come back
			rd_owner <= grant & {mips_pkg::req_n{~mem_we}};
		end
	end

	assign rvalid = rd_owner;
	assign rdata = mem_rdata;

endmodule

// ==== design/mips_pkg.sv ====
package mips_pkg;

	////////////////////
	// Sizes
	////////////////////

	// Data and instruction word
	localparam int word_w = 32;
	// Word address into the unified memory
	localparam int addr_w = 8;
	localparam int mem_depth = 256;
	// Register index
	localparam int reg_addr_w = 5;

	////////////////////
	// Arbiter requesters
	////////////////////

	// Bit positions in req, grant and rvalid, lowest index wins
	localparam int req_host = 0;
	localparam int req_data = 1;
	localparam int req_fetch = 2;
	localparam int req_n = 3;

	////////////////////
	// Encodings
	////////////////////

	// Primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		op_rtype = 6'd0,
		op_beq = 6'd4,
		op_lw = 6'd35,
		op_sw = 6'd43,
		op_halt = 6'd63
	} opcode_e;

	// R-type funct field, instr[5:0]
	typedef enum logic [5:0] {
		fn_add = 6'd32,
		fn_sub = 6'd34,
		fn_and = 6'd36,
		fn_or = 6'd37,
		fn_slt = 6'd42
	} funct_e;

	// ALUOp group from the decoder
	typedef enum logic [1:0] {
		aluop_add = 2'b00,
		aluop_sub = 2'b01,
		aluop_funct = 2'b10
	} aluop_e;

	// Execute unit sequencer
	typedef enum logic [1:0] {
		st_idle,
		st_exec,
		st_mem,
		st_wb
	} exec_state_e;

endpackage

// ==== design/mips_top.sv ====
`timescale 1ns/1ps

module mips_top (
	input logic clk,
	input logic rst,
	input logic run,
	output logic halted,
	// Host loader port
	input logic host_req,
	input logic host_we,
	input logic [mips_pkg::addr_w-1:0] host_addr,
	input logic [mips_pkg::word_w-1:0] host_wdata,
	output logic host_grant,
	output logic [mips_pkg::word_w-1:0] host_rdata,
	output logic host_rvalid
);

	logic [mips_pkg::req_n-1:0] arb_req;
	logic [mips_pkg::req_n-1:0] arb_grant;
	logic [mips_pkg::req_n-1:0] arb_rvalid;
	logic [mips_pkg::word_w-1:0] arb_rdata;

	logic fetch_req;
	logic [mips_pkg::addr_w-1:0] fetch_addr;
	logic [mips_pkg::word_w-1:0] instr;
	logic [mips_pkg::addr_w-1:0] instr_pc;
	logic instr_valid;
	logic instr_take;
	logic branch_taken;
	logic [mips_pkg::addr_w-1:0] branch_target;

	logic data_req;
	logic data_we;
	logic [mips_pkg::addr_w-1:0] data_addr;
	logic [mips_pkg::word_w-1:0] data_wdata;

	logic mem_en;
	logic mem_we;
	logic [mips_pkg::addr_w-1:0] mem_addr;
	logic [mips_pkg::word_w-1:0] mem_wdata;
	logic [mips_pkg::word_w-1:0] mem_rdata;

	// Requester slots in the arbiter vectors
	assign arb_req[mips_pkg::req_host] = host_req;
	assign arb_req[mips_pkg::req_data] = data_req;
	assign arb_req[mips_pkg::req_fetch] = fetch_req;
	assign host_grant = arb_grant[mips_pkg::req_host];
	assign host_rvalid = arb_rvalid[mips_pkg::req_host];
	assign host_rdata = arb_rdata;

	fetch_unit fetch_unit_i (
		.clk(clk),
		.rst(rst),
		.halted(halted),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.instr_take(instr_take),
		.grant(arb_grant[mips_pkg::req_fetch]),
		.rvalid(arb_rvalid[mips_pkg::req_fetch]),
		.rdata(arb_rdata),
		.req(fetch_req),
		.addr(fetch_addr),
		.instr(instr),
		.instr_pc(instr_pc),
		.instr_valid(instr_valid)
	);

	exec_unit exec_unit_i (
		.clk(clk),
		.rst(rst),
		.run(run),
		.instr(instr),
		.instr_pc(instr_pc),
		.instr_valid(instr_valid),
		.instr_take(instr_take),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.halted(halted),
		.data_req(data_req),
		.data_we(data_we),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_grant(arb_grant[mips_pkg::req_data]),
		.data_rvalid(arb_rvalid[mips_pkg::req_data]),
		.data_rdata(arb_rdata)
	);

	// Fetch only ever reads
	mem_arbiter mem_arbiter_i (
		.clk(clk),
		.rst(rst),
		.req(arb_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.data_we(data_we),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.fetch_we(1'b0),
		.fetch_addr(fetch_addr),
		.fetch_wdata('0),
		.grant(arb_grant),
		.rvalid(arb_rvalid),
		.mem_en(mem_en),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.rdata(arb_rdata)
	);

	unified_mem unified_mem_i (
		.clk(clk),
		.en(mem_en),
		.we(mem_we),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input logic clk,
	input logic rst,
	input logic [mips_pkg::reg_addr_w-1:0] rs_addr,
	input logic [mips_pkg::reg_addr_w-1:0] rt_addr,
	input logic [mips_pkg::reg_addr_w-1:0] wr_addr,
	input logic wr_en,
	input logic [mips_pkg::word_w-1:0] wr_data,
	output logic [mips_pkg::word_w-1:0] rs_data,
	output logic [mips_pkg::word_w-1:0] rt_data
);

	logic [mips_pkg::word_w-1:0] regs [2**mips_pkg::reg_addr_w];

	// Single write port
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**mips_pkg::reg_addr_w; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			// $zero never takes a write
			regs[wr_addr] <= wr_data;
		end
	end

	// Asynchronous read ports
	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

endmodule

// ==== design/unified_mem.sv ====
`timescale 1ns/1ps

module unified_mem (
	input logic clk,
	input logic en,
	input logic we,
	input logic [mips_pkg::addr_w-1:0] addr,
	input logic [mips_pkg::word_w-1:0] wdata,
	output logic [mips_pkg::word_w-1:0] rdata
);

	// Program and data share this array
	logic [mips_pkg::word_w-1:0] mem [mips_pkg::mem_depth];

	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
			end else begin
				// Read data valid the next cycle
				rdata <= mem[addr];
			end
		end
	end

endmodule

// ==== dv/mips_asserts.sv ====
`timescale 1ns/1ps

module mips_asserts (
	input logic clk,
	input logic rst,
	input logic run,
	input logic halted,
	input logic [mips_pkg::req_n-1:0] grant,
	input logic [mips_pkg::req_n-1:0] rvalid,
	input logic mem_we,
	input logic fetch_req
);

	////////////////////
	// Arbiter
	////////////////////

	// One owner of the memory port per cycle
	a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(grant))
		else $error("more than one grant in a cycle");

	// Read data returns to last cycle's reader
	a_rvalid_follows: assert property (@(posedge clk) disable iff (rst)
		(|rvalid) |-> ((rvalid == $past(grant)) && !$past(mem_we)))
		else $error("rvalid without a read grant one cycle before");

	////////////////////
	// Halt
	////////////////////

	// Only run releases the core
	a_halted_sticky: assert property (@(posedge clk) disable iff (rst)
		(halted && !run) |=> halted)
		else $error("halted dropped without run");

	a_no_fetch_halted: assert property (@(posedge clk) disable iff (rst)
		halted |-> !fetch_req)
		else $error("fetch request while halted");

endmodule

// Watch the arbiter vectors from the top level
bind mips_top mips_asserts mips_asserts_i (
	.clk(clk),
	.rst(rst),
	.run(run),
	.halted(halted),
	.grant(arb_grant),
	.rvalid(arb_rvalid),
	.mem_we(mem_we),
	.fetch_req(fetch_req)
);

// ==== dv/mips_tb.sv ====
`timescale 1ns/1ps

module mips_tb;

	localparam int n_rows = 4;
	localparam int prog_w = 32;
	localparam int chk_w = 4;
	localparam int data_base = 64;
	localparam int data_n = 8;
	localparam int wait_max = 2000;

	logic clk;
	logic rst;
	logic run;
	logic halted;
	logic host_req;
	logic host_we;
	logic [mips_pkg::addr_w-1:0] host_addr;
	logic [mips_pkg::word_w-1:0] host_wdata;
	logic host_grant;
	logic [mips_pkg::word_w-1:0] host_rdata;
	logic host_rvalid;

	// Program rows and the addresses each one leaves results in
	logic [31:0] prog [n_rows][prog_w];
	logic [7:0] chk [n_rows][chk_w];
	// Reference copy of the memory
	logic [31:0] model_mem [mips_pkg::mem_depth];
	logic [15:0] lfsr;

	tb_clock clock_i (.clk(clk));

	mips_top mips_top_i (
		.clk(clk),
		.rst(rst),
		.run(run),
		.halted(halted),
		.host_req(host_req),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_grant(host_grant),
		.host_rdata(host_rdata),
		.host_rvalid(host_rvalid)
	);

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		// Galois form, taps 16 14 13 11
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic next_word(output logic [31:0] w);
		w = '0;
		for (int i = 0; i < 32; i++) begin
			w = {w[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic logic [31:0] fill_word(input logic [7:0] a);
		return {a, ~a, a ^ 8'h5A, 8'hC3};
	endfunction

	// Instruction encoders
	function automatic logic [31:0] r_op(input logic [4:0] rd, input logic [4:0] rs,
		input logic [4:0] rt, input logic [5:0] fn);
		return {6'd0, rs, rt, rd, 5'd0, fn};
	endfunction

	// lw or sw against $zero plus a word address
	function automatic logic [31:0] mem_op(input logic [5:0] op, input logic [4:0] rt,
		input logic [7:0] word);
		return {op, 5'd0, rt, 6'd0, word, 2'b00};
	endfunction

	function automatic logic [31:0] beq_op(input logic [4:0] rs, input logic [4:0] rt,
		input logic [15:0] off);
		return {mips_pkg::op_beq, rs, rt, off};
	endfunction

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic timed_out(input string what);
		$display("Timeout while waiting for %s", what);
		$display("CHECKS FAILED");
		$fatal(1, "wait timed out");
	endtask

	// One host access, returns read data for reads
	task automatic host_access(input logic we, input logic [7:0] a, input logic [31:0] wd,
		output logic [31:0] rd);
		int n;
		@(posedge clk);
		host_req <= 1'b1;
		host_we <= we;
		host_addr <= a;
		host_wdata <= wd;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > wait_max) timed_out("host grant");
		end while (!host_grant);
		@(posedge clk);
		host_req <= 1'b0;
		host_we <= 1'b0;
		rd = '0;
		if (!we) begin
			n = 0;
			do begin
				@(negedge clk);
				n++;
				if (n > wait_max) timed_out("host read data");
			end while (!host_rvalid);
			rd = host_rdata;
		end
	endtask

	task automatic host_write(input logic [7:0] a, input logic [31:0] wd);
		logic [31:0] unused;
		host_access(1'b1, a, wd, unused);
		model_mem[a] = wd;
	endtask

	task automatic wait_halted(input logic level);
		int n;
		n = 0;
		while (halted !== level) begin
			@(negedge clk);
			n++;
			if (n > wait_max) timed_out(level ? "halted to rise" : "halted to fall");
		end
	endtask

	////////////////////
	// ISA reference model
	////////////////////

	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] ins;
		logic [31:0] sum;
		logic [31:0] a;
		logic [31:0] b;
		logic [7:0] pc;
		logic done;
		for (int i = 0; i < 32; i++) regs[i] = '0;
		pc = '0;
		done = 1'b0;
		for (int step = 0; step < 500 && !done; step++) begin
			ins = model_mem[pc];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			sum = a + {{16{ins[15]}}, ins[15:0]};
			pc = pc + 8'd1;
			case (ins[31:26])
				6'd0: begin
					case (ins[5:0])
						6'd32: sum = a + b;
						6'd34: sum = a - b;
						6'd36: sum = a & b;
						6'd37: sum = a | b;
						6'd42: sum = {31'd0, $signed(a) < $signed(b)};
						default: sum = '0;
					endcase
					if (ins[15:11] != 5'd0) regs[ins[15:11]] = sum;
				end
				6'd35: if (ins[20:16] != 5'd0) regs[ins[20:16]] = model_mem[sum[9:2]];
				6'd43: model_mem[sum[9:2]] = b;
				// Offset in words from the next PC
				6'd4: if (a == b) pc = pc + ins[7:0];
				default: done = 1'b1;
			endcase
		end
	endtask

	////////////////////
	// Program table
	////////////////////

	task automatic build_table();
		for (int r = 0; r < n_rows; r++) begin
			for (int i = 0; i < prog_w; i++) prog[r][i] = {mips_pkg::op_halt, 26'd0};
		end
		// Every R-type op, then a store after halt
		prog[0][0] = mem_op(mips_pkg::op_lw, 1, 64);
		prog[0][1] = mem_op(mips_pkg::op_lw, 2, 65);
		prog[0][2] = r_op(3, 1, 2, mips_pkg::fn_add);
		prog[0][3] = mem_op(mips_pkg::op_sw, 3, 80);
		prog[0][4] = r_op(4, 1, 2, mips_pkg::fn_sub);
		prog[0][5] = mem_op(mips_pkg::op_sw, 4, 81);
		prog[0][6] = r_op(5, 1, 2, mips_pkg::fn_and);
		prog[0][7] = r_op(6, 1, 2, mips_pkg::fn_or);
		prog[0][8] = r_op(7, 2, 1, mips_pkg::fn_slt);
		// and minus or, so a swap of the two shows up
		prog[0][9] = r_op(5, 5, 6, mips_pkg::fn_sub);
		prog[0][10] = r_op(5, 5, 7, mips_pkg::fn_add);
		prog[0][11] = mem_op(mips_pkg::op_sw, 5, 82);
		prog[0][13] = mem_op(mips_pkg::op_sw, 1, 83);
		chk[0] = '{80, 81, 82, 83};
		// Copies through lw and sw
		prog[1][0] = mem_op(mips_pkg::op_lw, 1, 66);
		prog[1][1] = mem_op(mips_pkg::op_sw, 1, 90);
		prog[1][2] = mem_op(mips_pkg::op_lw, 2, 67);
		prog[1][3] = mem_op(mips_pkg::op_sw, 2, 91);
		prog[1][4] = mem_op(mips_pkg::op_lw, 3, 64);
		prog[1][5] = mem_op(mips_pkg::op_sw, 3, 92);
		prog[1][7] = mem_op(mips_pkg::op_sw, 3, 93);
		chk[1] = '{90, 91, 92, 93};
		// Taken beq then a not-taken one, markers from r8 and r9
		prog[2][0] = mem_op(mips_pkg::op_lw, 1, 64);
		prog[2][1] = mem_op(mips_pkg::op_lw, 2, 65);
		prog[2][2] = mem_op(mips_pkg::op_lw, 8, 68);
		prog[2][3] = mem_op(mips_pkg::op_lw, 9, 69);
		prog[2][4] = beq_op(1, 1, 16'd1);
		prog[2][5] = mem_op(mips_pkg::op_sw, 8, 100);
		prog[2][6] = mem_op(mips_pkg::op_sw, 9, 101);
		prog[2][7] = beq_op(1, 2, 16'd1);
		prog[2][8] = mem_op(mips_pkg::op_sw, 8, 102);
		prog[2][9] = mem_op(mips_pkg::op_sw, 9, 103);
		chk[2] = '{100, 101, 102, 103};
		// New program on a later run
		prog[3][0] = mem_op(mips_pkg::op_lw, 1, 70);
		prog[3][1] = mem_op(mips_pkg::op_lw, 2, 71);
		prog[3][2] = r_op(3, 2, 1, mips_pkg::fn_slt);
		prog[3][3] = mem_op(mips_pkg::op_sw, 3, 110);
		prog[3][4] = r_op(4, 2, 1, mips_pkg::fn_sub);
		prog[3][5] = mem_op(mips_pkg::op_sw, 4, 111);
		prog[3][6] = r_op(5, 1, 2, mips_pkg::fn_or);
		prog[3][7] = mem_op(mips_pkg::op_sw, 5, 112);
		// Halt at 8 hides this store
		prog[3][9] = mem_op(mips_pkg::op_sw, 4, 113);
		chk[3] = '{110, 111, 112, 113};
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		logic [31:0] w;
		rst = 1'b1;
		run = 1'b0;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		lfsr = 16'd16;
		build_table();
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		@(negedge clk);
		check_eq({31'd0, halted}, 32'd1, "halted after reset");
		host_write(8'd200, 32'h1234ABCD);
		host_access(1'b0, 8'd200, '0, w);
		check_eq(w, 32'h1234ABCD, "host readback");

		for (int r = 0; r < n_rows; r++) begin
			for (int i = 0; i < prog_w; i++) host_write(i[7:0], prog[r][i]);
			for (int i = 0; i < data_n; i++) begin
				next_word(w);
				host_write(8'(data_base + i), w);
			end
			for (int c = 0; c < chk_w; c++) host_write(chk[r][c], fill_word(chk[r][c]));
			run_model();

			// Run pulse, then the program ends on its halt
			@(posedge clk);
			run <= 1'b1;
			@(posedge clk);
			run <= 1'b0;
			wait_halted(1'b0);
			wait_halted(1'b1);

			for (int c = 0; c < chk_w; c++) begin
				host_access(1'b0, chk[r][c], '0, w);
				check_eq(w, model_mem[chk[r][c]], $sformatf("row %0d addr %0d", r, chk[r][c]));
			end
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	// Half of the 100 ns period
	localparam time half_period = 50ns;

	initial begin
		clk = 1'b0;
	end

	always begin
		#(half_period);
		clk = ~clk;
	end

endmodule

// ==== mips_sys.f ====
design/mips_pkg.sv
design/control_unit.sv
design/alu.sv
design/reg_file.sv
design/unified_mem.sv
design/mem_arbiter.sv
design/fetch_unit.sv
design/exec_unit.sv
design/mips_top.sv
dv/tb_clock.sv
dv/mips_asserts.sv
dv/mips_tb.sv
